//--- hdl/ball_mover.sv
`timescale 1ns/1ps

module ball_mover (
	input	logic				clk,
	input	logic				resetN,
	input	logic				tick,
	input	logic				pause,
	input	logic				reset_level,
	input	field_geom_pkg::coord_t		paddle_x,
	input	logic				brick_present,
	input	logic				brick_bad,
	output	logic				probe_valid,
	output	field_geom_pkg::coord_t		probe_col,
	output	field_geom_pkg::coord_t		ball_x,
	output	field_geom_pkg::coord_t		ball_y,
	output	logic				hit_good,
	output	logic				miss
);

	localparam field_geom_pkg::coord_t X_MAX =
		field_geom_pkg::coord_t'(field_geom_pkg::FIELD_W - 1);
	localparam field_geom_pkg::coord_t Y_MAX =
		field_geom_pkg::coord_t'(field_geom_pkg::FIELD_H - 1);

	logic dir_right; // 1 moves right.
	logic dir_up; // 1 moves toward row 0.
	logic step;
	logic near_paddle;
	logic dir_right_mv;
	field_geom_pkg::coord_t x_next;
	logic [4:0] x_ext, p_ext;

	assign step = tick && !pause && !reset_level;

	// Brick query from row 1 on the way up.
	assign probe_valid = step && dir_up && (ball_y == 4'd1);
	assign probe_col = ball_x;

	// Paddle covers its own column and one on each side.
	always_comb begin
		x_ext = {1'b0, ball_x};
		p_ext = {1'b0, paddle_x};
		near_paddle = (x_ext == p_ext) ||
			(x_ext + 5'd1 == p_ext) ||
			(p_ext + 5'd1 == x_ext);
	end

	// Side walls flip the direction before the move.
	always_comb begin
		dir_right_mv = dir_right;
		if (dir_right && (ball_x == X_MAX))
			dir_right_mv = 1'b0;
		else if (!dir_right && (ball_x == '0))
			dir_right_mv = 1'b1;
		x_next = dir_right_mv ? ball_x + 4'd1 : ball_x - 4'd1;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			ball_x <= field_geom_pkg::SERVE_X;
			ball_y <= field_geom_pkg::SERVE_Y;
			dir_right <= 1'b1;
			dir_up <= 1'b1;
			hit_good <= 1'b0;
			miss <= 1'b0;
		end
		else begin
			hit_good <= probe_valid && brick_present && !brick_bad;
			miss <= 1'b0;

			if (reset_level) begin
				ball_x <= field_geom_pkg::SERVE_X; // Parked, heading up-right.
				ball_y <= field_geom_pkg::SERVE_Y;
				dir_right <= 1'b1;
				dir_up <= 1'b1;
			end
			else if (step) begin
				if (dir_up) begin
					ball_x <= x_next;
					dir_right <= dir_right_mv;
					if (ball_y == '0) begin
						dir_up <= 1'b0; // Top edge acts as a wall.
						ball_y <= ball_y + 4'd1;
					end
					else if (probe_valid && brick_present) begin
						dir_up <= 1'b0; // Brick hit, stay in row 1.
					end
					else begin
						ball_y <= ball_y - 4'd1;
					end
				end
				else if (ball_y != Y_MAX) begin
					ball_x <= x_next;
					dir_right <= dir_right_mv;
					ball_y <= ball_y + 4'd1;
				end
				else if (near_paddle) begin
					ball_x <= x_next;
					dir_right <= dir_right_mv;
					dir_up <= 1'b1;
					ball_y <= ball_y - 4'd1;
				end
				else begin
					miss <= 1'b1; // Ball held until the restart.
				end
			end
		end
	end

endmodule

//--- hdl/brick_field.sv
`timescale 1ns/1ps

module brick_field #(
	parameter int BRICK_COLS = 8
) (
	input	logic				clk,
	input	logic				resetN,
	input	logic				reset_level_pulse,
	input	logic				probe_valid,
	input	field_geom_pkg::coord_t		probe_col,
	input	logic [BRICK_COLS-1:0]		bad_mask,
	output	logic				brick_present,
	output	logic				brick_bad,
	output	logic [BRICK_COLS-1:0]		bricks
);

	logic [BRICK_COLS-1:0] hit_sel;

	// One-hot select of the probed column, empty past the last brick.
	always_comb begin
		hit_sel = '0;
		for (int i = 0; i < BRICK_COLS; i++) begin
			if (probe_valid && (probe_col == field_geom_pkg::coord_t'(i)))
				hit_sel[i] = 1'b1;
		end
	end

	assign brick_present = |(hit_sel & bricks);
	assign brick_bad = |(hit_sel & bricks & bad_mask);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bricks <= '1;
		end
		else if (reset_level_pulse) begin
			bricks <= '1; // New level, full row.
		end
		else begin
			// Good bricks go away when hit.
			bricks <= bricks & ~(hit_sel & ~bad_mask);
		end
	end

endmodule

//--- hdl/field_geom_pkg.sv
package field_geom_pkg;

	// Cell coordinate, wide enough for the field plus one.
	typedef logic [3:0] coord_t;

	// Field size in cells. Row 0 holds the bricks.
	localparam int FIELD_W = 8;
	localparam int FIELD_H = 8;

	// Ball position while a level restarts.
	localparam coord_t SERVE_X = 4'd4;
	localparam coord_t SERVE_Y = 4'd6;

	// Config register map.
	localparam logic CFG_ADDR_LIFE = 1'b0; // Starting lives.
	localparam logic CFG_ADDR_MASK = 1'b1; // Bad-brick mask.

endpackage

//--- hdl/game_config_regs.sv
`timescale 1ns/1ps

module game_config_regs #(
	parameter int BRICK_COLS = 8
) (
	input	logic				clk,
	input	logic				resetN,
	input	logic				cfg_valid,
	input	logic				cfg_addr,
	input	logic [7:0]			cfg_data,
	input	logic				pause,
	output	logic				cfg_ready,
	output	game_rules_pkg::life_t		life_init,
	output	logic [BRICK_COLS-1:0]		bad_mask
);

	logic wr_en;

	// Settings only change between rounds.
	assign cfg_ready = pause;
	assign wr_en = cfg_valid && cfg_ready;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			life_init <= game_rules_pkg::LIFE_INIT;
			bad_mask <= '0; // All bricks good.
		end
		else if (wr_en) begin
			if (cfg_addr == field_geom_pkg::CFG_ADDR_LIFE) begin
				life_init <= cfg_data[3:0];
			end
			else if (cfg_addr == field_geom_pkg::CFG_ADDR_MASK) begin
				bad_mask <= cfg_data[BRICK_COLS-1:0];
			end
			// Any other address is taken and dropped.
		end
	end

endmodule

//--- hdl/game_controller.sv
`timescale 1ns/1ps

module game_controller (
	input	logic				clk,
	input	logic				resetN,
	input	logic				start,
	input	logic				launch,
	input	logic				hit_good,
	input	logic				miss,
	input	game_rules_pkg::life_t		life_init,
	output	logic				pause,
	output	logic				reset_level,
	output	logic				reset_level_pulse,
	output	game_rules_pkg::score_t		score,
	output	game_rules_pkg::life_t		life
);

	game_rules_pkg::game_state_t state, state_next;

	game_rules_pkg::score_t score_q, score_next;
	game_rules_pkg::life_t life_q, life_next;

	logic reset_level_d;

	assign score = score_q;
	assign life = life_q;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= game_rules_pkg::st_idle;
			score_q <= '0;
			life_q <= game_rules_pkg::LIFE_INIT;
			reset_level_d <= 1'b0;
		end
		else begin
			state <= state_next;
			score_q <= score_next;
			life_q <= life_next;
			reset_level_d <= reset_level;
		end
	end

	// First cycle of a restart.
	assign reset_level_pulse = reset_level && !reset_level_d;

	always_comb begin
		state_next = state;
		score_next = score_q;
		life_next = life_q;
		pause = 1'b1;
		reset_level = 1'b0;

		case (state)

			game_rules_pkg::st_idle: begin
				if (start)
					state_next = game_rules_pkg::st_serve;
			end

			game_rules_pkg::st_serve: begin
				score_next = '0;
				reset_level = 1'b1;
				if (launch)
					state_next = game_rules_pkg::st_play;
			end

			game_rules_pkg::st_play: begin
				pause = 1'b0;
				if (miss) begin
					life_next = life_q - 4'd1;
					if (life_next == '0)
						state_next = game_rules_pkg::st_over;
					else
						state_next = game_rules_pkg::st_serve;
				end
				else if (hit_good) begin
					score_next = score_q + 4'd1; // Wraps.
				end
			end

			game_rules_pkg::st_over: begin
				score_next = '0;
				life_next = life_init;
				reset_level = 1'b1;
				if (launch)
					state_next = game_rules_pkg::st_play;
			end

			default: begin
				state_next = game_rules_pkg::st_idle;
			end

		endcase
	end

endmodule

//--- hdl/game_rules_pkg.sv
package game_rules_pkg;

	// Score counts good bricks and wraps after 15.
	typedef logic [3:0] score_t;

	// Remaining lives.
	typedef logic [3:0] life_t;

	// Lives at power-up, until the config block is written.
	localparam life_t LIFE_INIT = 4'd3;

	// Controller states.
	// st_idle   waits for start.
	// st_serve  ball parked, waits for the serve key.
	// st_play   ball moving.
	// st_over   last life lost, waits for the serve key.
	typedef enum logic [1:0] {
		st_idle,
		st_serve,
		st_play,
		st_over
	} game_state_t;

endpackage

//--- hdl/game_top.sv
`timescale 1ns/1ps

module game_top #(
	parameter int BRICK_COLS = 8
) (
	input	logic				clk,
	input	logic				resetN,
	input	logic				start,
	input	logic				launch,
	input	logic				tick,
	input	field_geom_pkg::coord_t		paddle_x,
	input	logic				cfg_valid,
	input	logic				cfg_addr,
	input	logic [7:0]			cfg_data,
	output	logic				cfg_ready,
	output	logic				pause,
	output	game_rules_pkg::score_t		score,
	output	game_rules_pkg::life_t		life,
	output	field_geom_pkg::coord_t		ball_x,
	output	field_geom_pkg::coord_t		ball_y,
	output	logic [BRICK_COLS-1:0]		bricks
);

	game_rules_pkg::life_t life_init;
	logic [BRICK_COLS-1:0] bad_mask;
	logic reset_level, reset_level_pulse;
	logic hit_good, miss;
	logic probe_valid, brick_present, brick_bad;
	field_geom_pkg::coord_t probe_col;

	game_config_regs #(.BRICK_COLS(BRICK_COLS)) game_config_regs_i (
		.clk(clk), .resetN(resetN),
		.cfg_valid(cfg_valid), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.pause(pause), .cfg_ready(cfg_ready),
		.life_init(life_init), .bad_mask(bad_mask)
	);

	game_controller game_controller_i (
		.clk(clk), .resetN(resetN),
		.start(start), .launch(launch), .hit_good(hit_good), .miss(miss),
		.life_init(life_init), .pause(pause), .reset_level(reset_level),
		.reset_level_pulse(reset_level_pulse), .score(score), .life(life)
	);

	ball_mover ball_mover_i (
		.clk(clk), .resetN(resetN),
		.tick(tick), .pause(pause), .reset_level(reset_level), .paddle_x(paddle_x),
		.brick_present(brick_present), .brick_bad(brick_bad),
		.probe_valid(probe_valid), .probe_col(probe_col),
		.ball_x(ball_x), .ball_y(ball_y), .hit_good(hit_good), .miss(miss)
	);

	brick_field #(.BRICK_COLS(BRICK_COLS)) brick_field_i (
		.clk(clk), .resetN(resetN),
		.reset_level_pulse(reset_level_pulse),
		.probe_valid(probe_valid), .probe_col(probe_col), .bad_mask(bad_mask),
		.brick_present(brick_present), .brick_bad(brick_bad), .bricks(bricks)
	);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the game testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module game_tb -o game_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/game_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished cleanly"
exit 0

//--- tests/game_asserts.sv
`timescale 1ns/1ps

module game_asserts #(
	parameter int BRICK_COLS = 8
) (
	input	logic				clk,
	input	logic				resetN,
	input	logic				pause,
	input	logic				cfg_ready,
	input	logic				reset_level_pulse,
	input	logic [BRICK_COLS-1:0]		bricks,
	input	logic [BRICK_COLS-1:0]		bad_mask
);

	// Restart pulse is a single cycle.
	restart_pulse_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
		reset_level_pulse |=> !reset_level_pulse)
		else $error("reset_level_pulse held longer than one cycle");

	no_ready_in_play: assert property (@(posedge clk) disable iff (!resetN)
		!pause |-> !cfg_ready)
		else $error("cfg_ready high while the game is in play");

	// A present bad brick stays present.
	bad_brick_kept: assert property (@(posedge clk) disable iff (!resetN)
		(($past(bricks) & $past(bad_mask)) & ~bricks) == '0)
		else $error("bad brick was cleared");

endmodule

bind game_top game_asserts #(.BRICK_COLS(BRICK_COLS)) game_asserts_i (
	.clk(clk), .resetN(resetN), .pause(pause), .cfg_ready(cfg_ready),
	.reset_level_pulse(reset_level_pulse), .bricks(bricks), .bad_mask(bad_mask)
);

//--- tests/game_tb.sv
`timescale 1ns/1ps

module game_tb;

	localparam int BRICK_COLS = 8;
	localparam int TICK_BUDGET = 250;
	localparam int CLK_NS = 100;
	localparam int WATCHDOG_CYCLES = TICK_BUDGET * 4 + 300; // Ticks take three cycles each.
	localparam int WAIT_LIMIT = 20;

	logic clk;
	logic resetN;
	logic start;
	logic launch;
	logic tick;
	field_geom_pkg::coord_t paddle_x;
	logic cfg_valid;
	logic cfg_addr;
	logic [7:0] cfg_data;
	logic cfg_ready;
	logic pause;
	game_rules_pkg::score_t score;
	game_rules_pkg::life_t life;
	field_geom_pkg::coord_t ball_x;
	field_geom_pkg::coord_t ball_y;
	logic [BRICK_COLS-1:0] bricks;

	// Expected game state.
	int m_x, m_y, m_score, m_life, m_life_init;
	bit m_right, m_up;
	logic [BRICK_COLS-1:0] m_bricks, m_mask;
	integer seed;

	game_top #(.BRICK_COLS(BRICK_COLS)) game_top_i (
		.clk(clk), .resetN(resetN), .start(start), .launch(launch), .tick(tick),
		.paddle_x(paddle_x), .cfg_valid(cfg_valid), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .cfg_ready(cfg_ready), .pause(pause), .score(score),
		.life(life), .ball_x(ball_x), .ball_y(ball_y), .bricks(bricks)
	);

	always #(CLK_NS / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("Watchdog expired, the tests did not finish in time at %0t", $time);
		$display("=== FAIL ===");
		$fatal(1);
	end

	task automatic check(input string msg, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic serve_model();
		m_x = 4;
		m_y = 6;
		m_right = 1'b1;
		m_up = 1'b1;
	endtask

	// One frame of ball motion by the field rules.
	task automatic model_step(input int px, output bit missed);
		int col, nx, d;
		bit r;
		col = m_x;
		r = m_right;
		if (r && m_x == field_geom_pkg::FIELD_W - 1)
			r = 1'b0;
		else if (!r && m_x == 0)
			r = 1'b1;
		nx = r ? m_x + 1 : m_x - 1;
		d = (m_x > px) ? m_x - px : px - m_x;
		missed = 1'b0;
		if (m_up) begin
			m_x = nx;
			m_right = r;
			if (m_y == 0) begin
				m_up = 1'b0;
				m_y = 1;
			end
			else if (m_y == 1 && col < BRICK_COLS && m_bricks[col]) begin
				m_up = 1'b0; // Bounce, ball stays in row 1.
				if (!m_mask[col]) begin
					m_bricks[col] = 1'b0;
					m_score = (m_score + 1) % 16;
				end
			end
			else
				m_y = m_y - 1;
		end
		else if (m_y != field_geom_pkg::FIELD_H - 1) begin
			m_x = nx;
			m_right = r;
			m_y = m_y + 1;
		end
		else if (d <= 1) begin
			m_x = nx;
			m_right = r;
			m_up = 1'b1;
			m_y = m_y - 1;
		end
		else
			missed = 1'b1;
	endtask

	task automatic check_ball();
		check("ball_x", int'(ball_x), m_x);
		check("ball_y", int'(ball_y), m_y);
		check("score", int'(score), m_score);
		check("bricks", int'(bricks), int'(m_bricks));
	endtask

	// Tick pulse, then two edges for the score to settle.
	task automatic play_tick(input int px, output bit missed);
		@(negedge clk);
		paddle_x = field_geom_pkg::coord_t'(px);
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		@(negedge clk);
		model_step(px, missed);
		check_ball();
	endtask

	task automatic press_launch();
		@(negedge clk);
		launch = 1'b1;
		@(negedge clk);
		launch = 1'b0;
		check("pause after launch", int'(pause), 0);
		serve_model();
		check_ball();
	endtask

	task automatic track_ticks(input int n);
		bit missed;
		repeat (n) begin
			play_tick(m_x, missed);
			check("pause in play", int'(pause), int'(missed));
		end
	endtask

	// Follow the ball down, then move the paddle away from it.
	task automatic lose_ball();
		bit missed;
		int n, p;
		n = 0;
		while (!(m_y == field_geom_pkg::FIELD_H - 1 && !m_up)) begin
			if (n >= 40) begin
				$display("Ball never reached the bottom row at %0t", $time);
				$display("=== FAIL ===");
				$fatal(1);
			end
			play_tick(m_x, missed);
			n++;
		end
		p = $random(seed) & 7;
		while ((p > m_x ? p - m_x : m_x - p) < 2)
			p = $random(seed) & 7;
		play_tick(p, missed);
		check("pause after miss", int'(pause), int'(missed));
		m_life = m_life - 1;
		check("life two edges after the tick", int'(life), m_life);
		m_score = 0;
		m_bricks = '1;
		if (m_life == 0)
			m_life = m_life_init;
		repeat (3) @(negedge clk);
		serve_model();
		check("life after miss", int'(life), m_life);
		check_ball();
	endtask

	task automatic cfg_request(input logic addr, input int data);
		@(negedge clk);
		cfg_valid = 1'b1;
		cfg_addr = addr;
		cfg_data = 8'(data);
	endtask

	task automatic cfg_complete();
		int n;
		n = 0;
		while (!cfg_ready) begin
			if (n >= WAIT_LIMIT) begin
				$display("Config write was never accepted at %0t", $time);
				$display("=== FAIL ===");
				$fatal(1);
			end
			@(negedge clk);
			n++;
		end
		@(negedge clk);
		cfg_valid = 1'b0;
	endtask

	task automatic test_reset();
		check("pause at reset", int'(pause), 1);
		check("score at reset", int'(score), 0);
		check("life at reset", int'(life), 3);
		check("cfg_ready at reset", int'(cfg_ready), 1);
		check("bricks at reset", int'(bricks), 255);
	endtask

	task automatic test_track_and_hit();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check("pause in serve", int'(pause), 1);
		press_launch();
		track_ticks(20);
		check("score after hits", int'(score), m_score);
	endtask

	task automatic test_miss();
		lose_ball();
		check("life after first miss", int'(life), 2);
		check("score cleared in serve", int'(score), 0);
		press_launch();
		track_ticks(3);
	endtask

	task automatic test_cfg_backpressure();
		cfg_request(field_geom_pkg::CFG_ADDR_MASK, 'h20);
		@(negedge clk);
		check("cfg_ready in play", int'(cfg_ready), 0);
		lose_ball();
		cfg_complete();
		m_mask = 8'h20;
		// Starting lives for the game-over test.
		cfg_request(field_geom_pkg::CFG_ADDR_LIFE, 5);
		cfg_complete();
		m_life_init = 5;
		press_launch();
		track_ticks(6); // Sixth tick hits column 5.
		check("bad brick kept", int'(bricks[5]), 1);
		check("score after bad brick", int'(score), 0);
	endtask

	task automatic test_game_over();
		lose_ball();
		check("pause in game over", int'(pause), 1);
		check("score in game over", int'(score), 0);
		check("life reload", int'(life), 5);
		press_launch();
		check("life after relaunch", int'(life), 5);
		check("bricks after restart", int'(bricks), 255);
		track_ticks(2);
	endtask

	initial begin
		clk = 1'b0;
		resetN = 1'b0;
		start = 1'b0;
		launch = 1'b0;
		tick = 1'b0;
		paddle_x = '0;
		cfg_valid = 1'b0;
		cfg_addr = 1'b0;
		cfg_data = '0;
		seed = 32'h50201949;
		m_score = 0;
		m_life = 3;
		m_life_init = 3;
		m_bricks = '1;
		m_mask = '0;
		serve_model();

		repeat (8) @(negedge clk);
		resetN = 1'b1;
		@(negedge clk);

		test_reset();
		test_track_and_hit();
		test_miss();
		test_cfg_backpressure();
		test_game_over();

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- vlog.f
hdl/game_rules_pkg.sv
hdl/field_geom_pkg.sv
hdl/game_config_regs.sv
hdl/game_controller.sv
hdl/ball_mover.sv
hdl/brick_field.sv
hdl/game_top.sv
tests/game_asserts.sv
tests/game_tb.sv
